/* include/mem_cfg.svh */
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// sram geometry
// one 16-bit word per sram address
`define MEM_AW 18
`define MEM_DW 16

// low block number bits used
// placed above the 16-bit bus address
`define MEM_NB_USED 2

// clock cycles the sram strobe stays low
// read data taken in the last one
`define MEM_WAIT 2

`endif

/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	// bus operation taken from the active strobe
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

	// sram cycle sequencer
	typedef enum logic [2:0] {
		S_IDLE     = 3'd0,
		S_SETUP    = 3'd1,
		S_ACCESS   = 3'd2,
		S_DONE     = 3'd3,
		S_WAIT_ACK = 3'd4
	} seq_state_t;

	// bus reply driver
	typedef enum logic [1:0] {
		R_IDLE    = 2'd0,
		R_OK      = 2'd1,
		R_RELEASE = 2'd2
	} reply_state_t;

endpackage

`default_nettype wire

/* src/mem_req_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

interface mem_req_if ();

	import mem_pkg::*;

	// four-phase request, fields stable while req is high
	logic               req;
	bus_op_t            op;
	logic [`MEM_AW-1:0] addr;
	logic [`MEM_DW-1:0] wdata;
	// raised once the sequencer has latched the fields
	logic               ack;

	modport src (output req, op, addr, wdata, input ack);
	modport dst (input req, op, addr, wdata, output ack);

endinterface

`default_nettype wire

/* src/mem_rsp_if.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

interface mem_rsp_if ();

	import mem_pkg::*;

	// finished access, same four-phase rule as the request side
	logic               req;
	bus_op_t            op;
	logic [`MEM_DW-1:0] rdata;
	logic               ack;

	modport src (output req, op, rdata, input ack);
	modport dst (input req, op, rdata, output ack);

endinterface

`default_nettype wire

/* src/bus_receiver.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module bus_receiver (
	input  wire         clk,
	input  wire         rst_n,
	// active-low bus lines from the master
	input  wire         r_,
	input  wire         w_,
	input  wire  [3:0]  nb_,
	input  wire  [15:0] ad_,
	input  wire  [15:0] ddt_,
	mem_req_if.src      req_o,
	output logic        bus_idle
);

	import mem_pkg::*;

	logic [1:0] rd_sync;
	logic [1:0] wr_sync;
	logic       rd_act;
	logic       wr_act;
	logic       pending;
	logic       start;

// ----------------------------------------------------------------------
// strobe synchronizers
// ----------------------------------------------------------------------

	// two flops per strobe, stored active high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sync <= 2'b00;
			wr_sync <= 2'b00;
		end else begin
			rd_sync <= {rd_sync[0], ~r_};
			wr_sync <= {wr_sync[0], ~w_};
		end
	end

	assign rd_act = rd_sync[1];
	assign wr_act = wr_sync[1];

	// master has let go of both strobes
	assign bus_idle = !rd_act && !wr_act;

// ----------------------------------------------------------------------
// request handshake
// ----------------------------------------------------------------------

	// new strobe, nothing taken for it yet, previous handshake closed
	assign start = (rd_act || wr_act) && !pending && !req_o.req && !req_o.ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_o.req <= 1'b0;
			pending   <= 1'b0;
		end else begin
			if (req_o.req && req_o.ack) begin
				req_o.req <= 1'b0;
			end else if (start) begin
				req_o.req <= 1'b1;
				pending   <= 1'b1;
			end
			// re-arm only once the strobe is gone
			if (pending && bus_idle) begin
				pending <= 1'b0;
			end
		end
	end

	// address and data already stable behind the synchronized strobe
	always_ff @(posedge clk) begin
		if (start) begin
			req_o.op    <= rd_act ? OP_READ : OP_WRITE;
			req_o.addr  <= {~nb_[`MEM_NB_USED-1:0], ~ad_};
			req_o.wdata <= ~ddt_;
		end
	end

endmodule

`default_nettype wire

/* src/sram_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module sram_sequencer (
	input  wire                clk,
	input  wire                rst_n,
	mem_req_if.dst             req_i,
	mem_rsp_if.src             rsp_o,
	// async sram, active-low strobes
	output logic [`MEM_AW-1:0] sram_a,
	output logic               sram_ce,
	output logic               sram_oe,
	output logic               sram_we,
	output logic               sram_ub,
	output logic               sram_lb,
	output logic [`MEM_DW-1:0] sram_dq_out,
	output logic               sram_dq_oe,
	input  wire  [`MEM_DW-1:0] sram_dq_in
);

	import mem_pkg::*;

	localparam int WCW = $clog2(`MEM_WAIT + 1);

	seq_state_t         state;
	bus_op_t            op_q;
	logic [WCW-1:0]     wait_cnt;
	logic [`MEM_DW-1:0] rdata_q;
	logic               take;
	logic               last_wait;

	// whole words only
	assign sram_ub = 1'b0;
	assign sram_lb = 1'b0;

	assign take      = (state == S_IDLE) && req_i.req && !req_i.ack;
	assign last_wait = (state == S_ACCESS) && (wait_cnt == '0);

	assign rsp_o.op    = op_q;
	assign rsp_o.rdata = rdata_q;

// ----------------------------------------------------------------------
// cycle state machine
// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_IDLE;
			req_i.ack  <= 1'b0;
			rsp_o.req  <= 1'b0;
			sram_ce    <= 1'b1;
			sram_oe    <= 1'b1;
			sram_we    <= 1'b1;
			sram_dq_oe <= 1'b0;
			wait_cnt   <= '0;
		end else begin
			// close the request handshake once req falls
			if (req_i.ack && !req_i.req) begin
				req_i.ack <= 1'b0;
			end
			case (state)
				S_IDLE: begin
					// address and write data go out here, one cycle ahead of ce
					if (take) begin
						req_i.ack  <= 1'b1;
						sram_dq_oe <= (req_i.op == OP_WRITE);
						state      <= S_SETUP;
					end
				end
				S_SETUP: begin
					sram_ce <= 1'b0;
					if (op_q == OP_READ) begin
						sram_oe <= 1'b0;
					end else begin
						sram_we <= 1'b0;
					end
					wait_cnt <= WCW'(`MEM_WAIT - 1);
					state    <= S_ACCESS;
				end
				S_ACCESS: begin
					// strobes low for MEM_WAIT cycles
					if (last_wait) begin
						sram_ce <= 1'b1;
						sram_oe <= 1'b1;
						sram_we <= 1'b1;
						state   <= S_DONE;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				S_DONE: begin
					// address and data held one more cycle, then bus released
					sram_dq_oe <= 1'b0;
					rsp_o.req  <= 1'b1;
					state      <= S_WAIT_ACK;
				end
				S_WAIT_ACK: begin
					// reply side stalls here while the master holds its strobe
					if (rsp_o.req && rsp_o.ack) begin
						rsp_o.req <= 1'b0;
					end else if (!rsp_o.req && !rsp_o.ack) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

// ----------------------------------------------------------------------
// address, data and read capture
// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (take) begin
			op_q        <= req_i.op;
			sram_a      <= req_i.addr;
			sram_dq_out <= req_i.wdata;
		end
		// sample at the end of the last wait cycle
		if (last_wait && (op_q == OP_READ)) begin
			rdata_q <= sram_dq_in;
		end
	end

endmodule

`default_nettype wire

/* src/bus_reply.sv */
`default_nettype none
`timescale 1ns/1ps

module bus_reply (
	input  wire         clk,
	input  wire         rst_n,
	mem_rsp_if.dst      rsp_i,
	// both synchronized strobes released
	input  wire         bus_idle,
	// active-low reply to the master
	output logic        ok_,
	output logic [15:0] rdt_
);

	import mem_pkg::*;

	reply_state_t state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= R_IDLE;
			ok_       <= 1'b1;
			rdt_      <= '1;
			rsp_i.ack <= 1'b0;
		end else begin
			case (state)
				R_IDLE: begin
					// finished access, answer the master
					if (rsp_i.req && !rsp_i.ack) begin
						ok_ <= 1'b0;
						// read data inverted onto the bus
						// writes leave rdt_ idle
						if (rsp_i.op == OP_READ) begin
							rdt_ <= ~rsp_i.rdata;
						end else begin
							rdt_ <= '1;
						end
						state <= R_OK;
					end
				end
				R_OK: begin
					// hold ok_ for as long as the strobe is down
					if (bus_idle) begin
						state <= R_RELEASE;
					end
				end
				R_RELEASE: begin
					// ok_ back up together with the internal ack
					if (!rsp_i.ack) begin
						ok_       <= 1'b1;
						rdt_      <= '1;
						rsp_i.ack <= 1'b1;
					end else if (!rsp_i.req) begin
						rsp_i.ack <= 1'b0;
						state     <= R_IDLE;
					end
				end
				default: begin
					state <= R_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/mera_mem.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mera_mem (
	input  wire                clk,
	input  wire                rst_n,
	// system bus, active low
	input  wire                r_,
	input  wire                w_,
	input  wire  [3:0]         nb_,
	input  wire  [15:0]        ad_,
	input  wire  [15:0]        ddt_,
	output wire                ok_,
	output wire  [15:0]        rdt_,
	// sram, data pad split outside
	output wire  [`MEM_AW-1:0] sram_a,
	output wire                sram_ce,
	output wire                sram_oe,
	output wire                sram_we,
	output wire                sram_ub,
	output wire                sram_lb,
	output wire  [`MEM_DW-1:0] sram_dq_out,
	output wire                sram_dq_oe,
	input  wire  [`MEM_DW-1:0] sram_dq_in
);

	mem_req_if req_bus ();
	mem_rsp_if rsp_bus ();

	wire bus_idle;

// ----------------------------------------------------------------------
// input side
// ----------------------------------------------------------------------

	bus_receiver u_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.r_       (r_),
		.w_       (w_),
		.nb_      (nb_),
		.ad_      (ad_),
		.ddt_     (ddt_),
		.req_o    (req_bus),
		.bus_idle (bus_idle)
	);

	// sram cycle
	sram_sequencer u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_i       (req_bus),
		.rsp_o       (rsp_bus),
		.sram_a      (sram_a),
		.sram_ce     (sram_ce),
		.sram_oe     (sram_oe),
		.sram_we     (sram_we),
		.sram_ub     (sram_ub),
		.sram_lb     (sram_lb),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in)
	);

	// output side
	bus_reply u_reply (
		.clk      (clk),
		.rst_n    (rst_n),
		.rsp_i    (rsp_bus),
		.bus_idle (bus_idle),
		.ok_      (ok_),
		.rdt_     (rdt_)
	);

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module sram_model (
	input  wire  [`MEM_AW-1:0] sram_a,
	input  wire                sram_ce,
	input  wire                sram_oe,
	input  wire                sram_we,
	input  wire  [`MEM_DW-1:0] sram_dq_out,
	input  wire                sram_dq_oe,
	output logic [`MEM_DW-1:0] sram_dq_in
);

	logic [`MEM_DW-1:0] mem [0:(1<<`MEM_AW)-1];

	// fill pattern built from every address bit
	initial begin
		for (int i = 0; i < (1 << `MEM_AW); i++) begin
			mem[i] = 16'(i) ^ {2'(i >> 16), 14'h0} ^ 16'h5a5a;
		end
	end

	// write through while ce and we are both low
	always @(sram_a or sram_ce or sram_we or sram_dq_out or sram_dq_oe) begin
		if (!sram_ce && !sram_we && sram_dq_oe) begin
			mem[sram_a] = sram_dq_out;
		end
	end

	// read path, pad released by the design
	assign sram_dq_in = (!sram_ce && !sram_oe && !sram_dq_oe) ? mem[sram_a] : '0;

endmodule

`default_nettype wire

/* testbench/mera_mem_assert.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mera_mem_assert (
	input wire               clk,
	input wire               rst_n,
	input wire               ok_,
	input wire [15:0]        rdt_,
	input wire [`MEM_AW-1:0] sram_a,
	input wire               sram_ce,
	input wire               sram_oe,
	input wire               sram_we,
	input wire               sram_dq_oe,
	input wire               req_req,
	input wire               req_ack,
	input wire               rsp_req,
	input wire               rsp_ack
);

	logic       prev_ok;
	logic       prev_ce;
	logic [1:0] ce_falls;

// ----------------------------------------------------------------------
// sram cycles per bus access
// ----------------------------------------------------------------------

	// cleared on each ok_ rising edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prev_ok  <= 1'b1;
			prev_ce  <= 1'b1;
			ce_falls <= 2'd0;
		end else begin
			prev_ok <= ok_;
			prev_ce <= sram_ce;
			if (!prev_ok && ok_) begin
				ce_falls <= 2'd0;
			end else if (prev_ce && !sram_ce && (ce_falls != 2'd3)) begin
				ce_falls <= ce_falls + 2'd1;
			end
		end
	end

	a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(!prev_ok && ok_) |-> (ce_falls == 2'd1))
		else $error("sram_ce did not fall exactly once for this bus access");

	// all outputs idle while reset is held
	a_reset: assert property (@(posedge clk)
		!rst_n |-> (ok_ && (rdt_ == 16'hffff) && sram_ce && sram_oe && sram_we && !sram_dq_oe))
		else $error("outputs not idle during reset");

// ----------------------------------------------------------------------
// sram strobes and internal handshakes
// ----------------------------------------------------------------------

	a_we_oe: assert property (@(posedge clk) disable iff (!rst_n)
		!(!sram_we && !sram_oe))
		else $error("sram_we and sram_oe low together");

	// pad driven only around a write
	a_dq_oe: assert property (@(posedge clk) disable iff (!rst_n)
		sram_dq_oe |-> sram_oe)
		else $error("sram_dq_oe high during a read");

	a_addr: assert property (@(posedge clk) disable iff (!rst_n)
		!sram_ce |=> (sram_ce || $stable(sram_a)))
		else $error("sram_a changed while sram_ce low");

	a_req_hs: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(req_req) |-> !req_ack)
		else $error("request raised while ack still high");

	a_rsp_hs: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rsp_req) |-> !rsp_ack)
		else $error("response raised while ack still high");

endmodule

bind mera_mem mera_mem_assert u_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.ok_        (ok_),
	.rdt_       (rdt_),
	.sram_a     (sram_a),
	.sram_ce    (sram_ce),
	.sram_oe    (sram_oe),
	.sram_we    (sram_we),
	.sram_dq_oe (sram_dq_oe),
	.req_req    (req_bus.req),
	.req_ack    (req_bus.ack),
	.rsp_req    (rsp_bus.req),
	.rsp_ack    (rsp_bus.ack)
);

`default_nettype wire

/* testbench/tb_mera_mem.sv */
`default_nettype none
`timescale 1ns/1ps

`include "mem_cfg.svh"

module tb_mera_mem;

	import mem_pkg::*;

	logic               clk;
	logic               rst_n;
	logic               r_;
	logic               w_;
	logic [3:0]         nb_;
	logic [15:0]        ad_;
	logic [15:0]        ddt_;
	wire                ok_;
	wire  [15:0]        rdt_;
	wire  [`MEM_AW-1:0] sram_a;
	wire                sram_ce;
	wire                sram_oe;
	wire                sram_we;
	wire                sram_ub;
	wire                sram_lb;
	wire  [`MEM_DW-1:0] sram_dq_out;
	wire                sram_dq_oe;
	wire  [`MEM_DW-1:0] sram_dq_in;

	// stimulus table, one entry per access
	bus_op_t            st_op[$];
	logic [3:0]         st_nb[$];
	logic [15:0]        st_ad[$];
	logic [`MEM_DW-1:0] st_wd[$];
	logic [`MEM_DW-1:0] st_exp[$];

	int         errors = 0;
	int         checks = 0;
	int         cycles = 0;
	int         cycle_limit = 0;
	int         ce_falls = 0;
	bit         file_ok = 1'b1;
	logic       prev_ce = 1'b1;
	bus_op_t    seen_op = OP_READ;
	logic [1:0] seen_lanes = 2'b11;

	mera_mem u_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.r_          (r_),
		.w_          (w_),
		.nb_         (nb_),
		.ad_         (ad_),
		.ddt_        (ddt_),
		.ok_         (ok_),
		.rdt_        (rdt_),
		.sram_a      (sram_a),
		.sram_ce     (sram_ce),
		.sram_oe     (sram_oe),
		.sram_we     (sram_we),
		.sram_ub     (sram_ub),
		.sram_lb     (sram_lb),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in)
	);

	sram_model u_sram (
		.sram_a      (sram_a),
		.sram_ce     (sram_ce),
		.sram_oe     (sram_oe),
		.sram_we     (sram_we),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_dq_in  (sram_dq_in)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

// ----------------------------------------------------------------------
// sram cycle monitor and timeout
// ----------------------------------------------------------------------

	always @(posedge clk) begin
		// strobe direction tells the operation
		if (prev_ce && !sram_ce) begin
			ce_falls   <= ce_falls + 1;
			seen_op    <= sram_we ? OP_READ : OP_WRITE;
			// byte lanes while the strobe is low
			seen_lanes <= {sram_ub, sram_lb};
		end
		prev_ce <= sram_ce;
		cycles  <= cycles + 1;
		if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
			$display("timeout after %0d cycles, an access never completed", cycles);
			$display("Result: FAILED");
			$finish;
		end
	end

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------

	task automatic check_word(input string name, input logic [`MEM_DW-1:0] got,
		input logic [`MEM_DW-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input bus_op_t got, input bus_op_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	// reset values of every DUT output
	task automatic check_idle(input string tag);
		check_bit({tag, " ok_"}, ok_, 1'b1);
		check_word({tag, " rdt_"}, rdt_, 16'hffff);
		check_bit({tag, " sram_ce"}, sram_ce, 1'b1);
		check_bit({tag, " sram_oe"}, sram_oe, 1'b1);
		check_bit({tag, " sram_we"}, sram_we, 1'b1);
		check_bit({tag, " sram_dq_oe"}, sram_dq_oe, 1'b0);
	endtask

// ----------------------------------------------------------------------
// stimulus file
// ----------------------------------------------------------------------

	task automatic load_stimulus();
		int                 fd;
		int                 rc;
		logic [63:0]        tok;
		logic [8*160-1:0]   rest;
		logic [3:0]         nb;
		logic [15:0]        ad;
		logic [`MEM_DW-1:0] wd;
		logic [`MEM_DW-1:0] ex;
		fd = $fopen("testbench/mem_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file testbench/mem_stimulus.txt");
			file_ok = 1'b0;
			return;
		end
		while (!$feof(fd)) begin
			tok = '0;
			rc = $fscanf(fd, "%s", tok);
			if (rc != 1) begin
				break;
			end
			if (tok == "#") begin
				// column header, rest of the line skipped
				rc = $fgets(rest, fd);
			end else begin
				rc = $fscanf(fd, "%h %h %h %h", nb, ad, wd, ex);
				if ((rc != 4) || ((tok != "R") && (tok != "W"))) begin
					$display("malformed stimulus entry after %0d accesses", st_op.size());
					file_ok = 1'b0;
					break;
				end
				st_op.push_back((tok == "W") ? OP_WRITE : OP_READ);
				st_nb.push_back(nb);
				st_ad.push_back(ad);
				st_wd.push_back(wd);
				st_exp.push_back(ex);
			end
		end
		$fclose(fd);
		if (st_op.size() == 0) begin
			$display("stimulus file holds no accesses");
			file_ok = 1'b0;
		end
	endtask

// ----------------------------------------------------------------------
// bus master
// ----------------------------------------------------------------------

	// one four-phase access, strobe held 0 to 5 extra cycles
	task automatic bus_access(input int idx);
		int                 hold;
		int                 base_err;
		int                 base_falls;
		logic [`MEM_DW-1:0] rd;
		hold       = int'($urandom % 6);
		base_err   = errors;
		base_falls = ce_falls;
		@(negedge clk);
		nb_  = ~st_nb[idx];
		ad_  = ~st_ad[idx];
		ddt_ = (st_op[idx] == OP_WRITE) ? ~st_wd[idx] : 16'hffff;
		if (st_op[idx] == OP_READ) begin
			r_ = 1'b0;
		end else begin
			w_ = 1'b0;
		end
		while (ok_ !== 1'b0) begin
			@(negedge clk);
		end
		rd = ~rdt_;
		if (st_op[idx] == OP_READ) begin
			check_word("rdt_", rd, st_exp[idx]);
		end else begin
			check_word("rdt_", rdt_, 16'hffff);
		end
		// ok_ must wait for the master
		repeat (hold) begin
			@(negedge clk);
			check_bit("ok_ during hold", ok_, 1'b0);
		end
		r_ = 1'b1;
		w_ = 1'b1;
		while (ok_ !== 1'b1) begin
			@(negedge clk);
		end
		check_word("rdt_ after release", rdt_, 16'hffff);
		nb_  = 4'hf;
		ad_  = 16'hffff;
		ddt_ = 16'hffff;
		if ((ce_falls - base_falls) != 1) begin
			errors++;
			$display("expected one sram cycle for access %0d, saw %0d",
				idx, ce_falls - base_falls);
		end
		check_op("sram cycle op", seen_op, st_op[idx]);
		// whole words only
		check_bit("sram_ub", seen_lanes[1], 1'b0);
		check_bit("sram_lb", seen_lanes[0], 1'b0);
		$display("access %0d %s nb=%h ad=%h wd=%h rd=%h hold=%0d %s", idx,
			st_op[idx].name(), st_nb[idx], st_ad[idx], st_wd[idx], rd, hold,
			(errors == base_err) ? "ok" : "error");
	endtask

	initial begin
		void'($urandom(32'hfa71893f));
		rst_n = 1'b1;
		r_    = 1'b1;
		w_    = 1'b1;
		nb_   = 4'hf;
		ad_   = 16'hffff;
		ddt_  = 16'hffff;
		load_stimulus();
		if (!file_ok) begin
			$display("Result: FAILED");
			$finish;
		end else begin
			cycle_limit = 40 * st_op.size() + 20;
			#1 rst_n = 1'b0;
			repeat (2) begin
				@(posedge clk);
			end
			@(negedge clk);
			check_idle("in reset");
			rst_n = 1'b1;
			@(negedge clk);
			check_idle("after reset");
			for (int i = 0; i < st_op.size(); i++) begin
				bus_access(i);
			end
			$display("accesses %0d, checks %0d, errors %0d", st_op.size(), checks, errors);
			if (errors == 0) begin
				$display("Result: PASSED");
			end else begin
				$display("Result: FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

/* testbench/mem_stimulus.txt */
# op nb ad wdata expect, all hex, true (not inverted) values
# W writes wdata, R reads and compares with expect, sram address is nb[1:0] above ad
W 0 1234 a5a5 0000
R 0 1234 0000 a5a5
W 1 1234 3c3c 0000
W 2 1234 0ff0 0000
W 3 1234 f00d 0000
R 1 1234 0000 3c3c
R 2 1234 0000 0ff0
R 3 1234 0000 f00d
R 4 1234 0000 a5a5
W 0 0000 ffff 0000
R 0 0000 0000 ffff
W 7 fffe 1357 0000
R 3 fffe 0000 1357
W 8 0042 8001 0000
R 0 0042 0000 8001
R c 0042 0000 8001
R 1 0100 0000 1b5a
R 3 0000 0000 9a5a
W 2 beef 0000 0000
R 6 beef 0000 0000

/* list.f */
+incdir+include
src/mem_pkg.sv
src/mem_req_if.sv
src/mem_rsp_if.sv
src/bus_receiver.sv
src/sram_sequencer.sv
src/bus_reply.sv
src/mera_mem.sv
testbench/sram_model.sv
testbench/mera_mem_assert.sv
testbench/tb_mera_mem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, status follows the result line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_mera_mem \
	-Mdir obj_dir -o tb_mera_mem \
	&& ./obj_dir/tb_mera_mem | tee /dev/stderr | grep -q "^Result: PASSED$" \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }
